//--- hw/mcast_pkg.sv
`default_nettype none

package mcast_pkg;

  // address and data sizes of the fabric
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;

  // four map rules feed four targets in the default layout
  localparam int unsigned NoRules = 4;
  localparam int unsigned NoIndices = 4;
  localparam int unsigned IdxWidth = 2;
  localparam int unsigned RuleSelWidth = 2;

  // each target is a 16-word window addressed by the low address bits
  localparam int unsigned WordsPerTarget = 16;
  localparam int unsigned OffsetWidth = 4;

  // the error counter saturates at its all-ones value
  localparam int unsigned ErrCountWidth = 8;

  // addresses and don't-care masks share one type
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [IdxWidth-1:0] idx_t;
  typedef logic [OffsetWidth-1:0] offset_t;

  // one map rule, where a set mask bit means the address bit can take any value
  typedef struct packed {
    idx_t  idx;
    addr_t addr;
    addr_t mask;
  } rule_t;

  // multicast write request as it enters the fabric
  typedef struct packed {
    addr_t addr;
    addr_t mask;
    data_t data;
  } wr_req_t;

  // write command for one target, in local word offsets
  typedef struct packed {
    logic    we;
    offset_t offset;
    offset_t offset_mask;
    data_t   data;
  } tgt_cmd_t;

  // reset map gives rule i to target i at window i*16#10
  localparam rule_t [NoRules-1:0] DefaultRuleAddr = {
    rule_t'{idx: idx_t'(3), addr: 16'h0030, mask: 16'h000F},
    rule_t'{idx: idx_t'(2), addr: 16'h0020, mask: 16'h000F},
    rule_t'{idx: idx_t'(1), addr: 16'h0010, mask: 16'h000F},
    rule_t'{idx: idx_t'(0), addr: 16'h0000, mask: 16'h000F}
  };

endpackage

`default_nettype wire

//--- hw/multiaddr_decode.sv
`timescale 1ns/100ps
`default_nettype none

// combinational decoder that checks an {addr, mask} address set against
// every rule of the map and returns, per target, the part of the set that
// falls inside that target's window
module multiaddr_decode (
  input  mcast_pkg::addr_t                               addr_i,
  input  mcast_pkg::addr_t                               mask_i,
  input  mcast_pkg::rule_t [mcast_pkg::NoRules-1:0]      addr_map_i,
  output logic             [mcast_pkg::NoIndices-1:0]    select_o,
  output mcast_pkg::addr_t [mcast_pkg::NoIndices-1:0]    addr_o,
  output mcast_pkg::addr_t [mcast_pkg::NoIndices-1:0]    mask_o,
  output logic                                           dec_valid_o,
  output logic                                           dec_error_o
);

  import mcast_pkg::*;

  // one bit per rule, handy when the map is being brought up
  logic [NoRules-1:0] matched_rules;

  // a rule matches when some address of the request set lies in the rule set
  // bits that are masked on either side are don't care for the comparison
  // all remaining bits have to agree between request and rule
  always_comb begin
    for (int r = 0; r < NoRules; r++) begin
      matched_rules[r] = &(mask_i | addr_map_i[r].mask | ~(addr_i ^ addr_map_i[r].addr));
    end
  end

  // resolve the matching subset for every selected target
  // rules are walked upwards, so a higher rule naming the same target
  // overwrites the subset of a lower one while select keeps both hits
  always_comb begin
    select_o = '0;
    addr_o   = '0;
    mask_o   = '0;
    for (int r = 0; r < NoRules; r++) begin
      if (matched_rules[r]) begin
        select_o[addr_map_i[r].idx] = 1'b1;
        // a bit stays free only if both the request and the rule leave it free
        mask_o[addr_map_i[r].idx] = mask_i & addr_map_i[r].mask;
        // request bits win where the request pins them down
        // bits the request leaves free take the rule's value
        addr_o[addr_map_i[r].idx] = (addr_i & ~mask_i) | (addr_map_i[r].addr & mask_i);
      end
    end
  end

  // any hit is a valid decode, no hit at all is an error
  assign dec_valid_o = |matched_rules;
  assign dec_error_o = ~(|matched_rules);

endmodule

`default_nettype wire

//--- hw/addr_map_regs.sv
`timescale 1ns/100ps
`default_nettype none

// register file holding the address map rules
// the decoder always sees the registered table, so a config write
// only affects requests from the next cycle onwards
module addr_map_regs (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic                                      cfg_we_i,
  input  logic [mcast_pkg::RuleSelWidth-1:0]        cfg_rule_sel_i,
  input  mcast_pkg::rule_t                          cfg_rule_i,
  output mcast_pkg::rule_t [mcast_pkg::NoRules-1:0] addr_map_o
);

  import mcast_pkg::*;

  rule_t [NoRules-1:0] map_q;
  logic  [NoRules-1:0] rule_we;

  // decode the config strobe into one write enable per rule
  always_comb begin
    for (int r = 0; r < NoRules; r++) begin
      rule_we[r] = cfg_we_i && (cfg_rule_sel_i == RuleSelWidth'(r));
    end
  end

  // reset restores the default layout with one window per target
  // afterwards each strobe replaces exactly one rule
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      map_q <= DefaultRuleAddr;
    end else begin
      for (int r = 0; r < NoRules; r++) begin
        if (rule_we[r]) begin
          map_q[r] <= cfg_rule_i;
        end
      end
    end
  end

  assign addr_map_o = map_q;

endmodule

`default_nettype wire

//--- hw/mcast_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

// pipeline stage between the decoder and the targets
// turns the resolved address sets into local word commands and keeps
// track of requests that hit no rule
module mcast_dispatch (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic                                          wr_valid_i,
  input  mcast_pkg::data_t                              wr_data_i,
  input  logic             [mcast_pkg::NoIndices-1:0]   select_i,
  input  mcast_pkg::addr_t [mcast_pkg::NoIndices-1:0]   addr_i,
  input  mcast_pkg::addr_t [mcast_pkg::NoIndices-1:0]   mask_i,
  input  logic                                          dec_error_i,
  output mcast_pkg::tgt_cmd_t [mcast_pkg::NoIndices-1:0] cmd_o,
  output logic                                          wr_error_o,
  output logic [mcast_pkg::ErrCountWidth-1:0]           err_count_o
);

  import mcast_pkg::*;

  logic    [NoIndices-1:0]     we_q;
  offset_t [NoIndices-1:0]     offset_q;
  offset_t [NoIndices-1:0]     offset_mask_q;
  data_t                       data_q;
  logic                        wr_error_q;
  logic [ErrCountWidth-1:0]    err_count_q;
  logic                        wr_unmatched;

  assign wr_unmatched = wr_valid_i && dec_error_i;

  // control side of the stage
  // a target only gets a write strobe if it was selected by a valid request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      we_q        <= '0;
      wr_error_q  <= 1'b0;
      err_count_q <= '0;
    end else begin
      we_q       <= wr_valid_i ? select_i : '0;
      wr_error_q <= wr_unmatched;
      // the counter sticks at its maximum instead of wrapping
      if (wr_unmatched && !(&err_count_q)) begin
        err_count_q <= err_count_q + 1'b1;
      end
    end
  end

  // payload side only needs to follow accepted requests
  // the upper address bits already matched the rule, so only the
  // offset part inside the 16-word window is forwarded
  always_ff @(posedge clk_i) begin
    if (wr_valid_i) begin
      data_q <= wr_data_i;
      for (int t = 0; t < NoIndices; t++) begin
        offset_q[t]      <= addr_i[t][OffsetWidth-1:0];
        offset_mask_q[t] <= mask_i[t][OffsetWidth-1:0];
      end
    end
  end

  // build one command per target, all of them share the request data
  always_comb begin
    for (int t = 0; t < NoIndices; t++) begin
      cmd_o[t].we          = we_q[t];
      cmd_o[t].offset      = offset_q[t];
      cmd_o[t].offset_mask = offset_mask_q[t];
      cmd_o[t].data        = data_q;
    end
  end

  assign wr_error_o  = wr_error_q;
  assign err_count_o = err_count_q;

endmodule

`default_nettype wire

//--- hw/mem_target.sv
`timescale 1ns/100ps
`default_nettype none

// small register memory used as a write target
// one command may cover several words, all of them get written in the
// same cycle, and reads come back one cycle after the request
module mem_target (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mcast_pkg::tgt_cmd_t   cmd_i,
  input  logic                  rd_en_i,
  input  mcast_pkg::offset_t    rd_word_i,
  output mcast_pkg::data_t      rd_data_o
);

  import mcast_pkg::*;

  data_t [WordsPerTarget-1:0] mem_q;
  logic  [WordsPerTarget-1:0] word_hit;
  data_t                      rd_data_q;

  // word j belongs to the command set when it agrees with the offset on
  // every bit that the offset mask leaves pinned
  always_comb begin
    for (int j = 0; j < WordsPerTarget; j++) begin
      word_hit[j] = ((offset_t'(j) ^ cmd_i.offset) & ~cmd_i.offset_mask) == '0;
    end
  end

  // memory starts out cleared so read-back of untouched words is zero
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mem_q <= '0;
    end else if (cmd_i.we) begin
      for (int j = 0; j < WordsPerTarget; j++) begin
        if (word_hit[j]) begin
          mem_q[j] <= cmd_i.data;
        end
      end
    end
  end

  // registered read port
  // the data register only loads on a read, valid is tracked at the top
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_q <= mem_q[rd_word_i];
    end
  end

  assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

//--- hw/mcast_fabric.sv
`timescale 1ns/100ps
`default_nettype none

// top level of the multicast write fabric
// a write goes through the map lookup and the dispatch register and
// lands in every target whose window overlaps the request set
module mcast_fabric (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               wr_valid_i,
  input  mcast_pkg::wr_req_t                 wr_req_i,
  input  logic                               cfg_we_i,
  input  logic [mcast_pkg::RuleSelWidth-1:0] cfg_rule_sel_i,
  input  mcast_pkg::rule_t                   cfg_rule_i,
  input  logic                               rd_en_i,
  input  mcast_pkg::idx_t                    rd_target_i,
  input  mcast_pkg::offset_t                 rd_word_i,
  output mcast_pkg::data_t                   rd_data_o,
  output logic                               rd_valid_o,
  output logic                               wr_error_o,
  output logic [mcast_pkg::ErrCountWidth-1:0] err_count_o
);

  import mcast_pkg::*;

  rule_t    [NoRules-1:0]   addr_map;
  logic     [NoIndices-1:0] dec_select;
  addr_t    [NoIndices-1:0] dec_addr;
  addr_t    [NoIndices-1:0] dec_mask;
  logic                     dec_error;
  tgt_cmd_t [NoIndices-1:0] tgt_cmd;
  logic     [NoIndices-1:0] tgt_rd_en;
  data_t    [NoIndices-1:0] tgt_rd_data;
  idx_t                     rd_target_q;
  logic                     rd_valid_q;

  addr_map_regs addr_map_regs_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_rule_sel_i (cfg_rule_sel_i),
    .cfg_rule_i     (cfg_rule_i),
    .addr_map_o     (addr_map)
  );

  multiaddr_decode multiaddr_decode_inst (
    .addr_i      (wr_req_i.addr),
    .mask_i      (wr_req_i.mask),
    .addr_map_i  (addr_map),
    .select_o    (dec_select),
    .addr_o      (dec_addr),
    .mask_o      (dec_mask),
    .dec_valid_o (),
    .dec_error_o (dec_error)
  );

  // the dispatcher turns the decode result into per-target commands
  mcast_dispatch mcast_dispatch_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wr_valid_i  (wr_valid_i),
    .wr_data_i   (wr_req_i.data),
    .select_i    (dec_select),
    .addr_i      (dec_addr),
    .mask_i      (dec_mask),
    .dec_error_i (dec_error),
    .cmd_o       (tgt_cmd),
    .wr_error_o  (wr_error_o),
    .err_count_o (err_count_o)
  );

  // only the addressed target sees the read strobe
  always_comb begin
    for (int t = 0; t < NoIndices; t++) begin
      tgt_rd_en[t] = rd_en_i && (rd_target_i == idx_t'(t));
    end
  end

  for (genvar t = 0; t < NoIndices; t++) begin : gen_target
    mem_target mem_target_inst (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .cmd_i     (tgt_cmd[t]),
      .rd_en_i   (tgt_rd_en[t]),
      .rd_word_i (rd_word_i),
      .rd_data_o (tgt_rd_data[t])
    );
  end

  // remember which target was read so its data can be picked next cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_valid_q  <= 1'b0;
      rd_target_q <= '0;
    end else begin
      rd_valid_q <= rd_en_i;
      if (rd_en_i) begin
        rd_target_q <= rd_target_i;
      end
    end
  end

  assign rd_valid_o = rd_valid_q;
  assign rd_data_o  = tgt_rd_data[rd_target_q];

endmodule

`default_nettype wire

//--- verif/mcast_fabric_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mcast_fabric_tb;

  import mcast_pkg::*;

  // five full read-backs of 64 words plus the writes and config strobes
  localparam int TestCycles = 3 + 5 * (NoIndices * WordsPerTarget + 4) + 40;

  logic clk_i = 1'b0;
  logic rst_n_i;
  logic wr_valid_i;
  wr_req_t wr_req_i;
  logic cfg_we_i;
  logic [RuleSelWidth-1:0] cfg_rule_sel_i;
  rule_t cfg_rule_i;
  logic rd_en_i;
  idx_t rd_target_i;
  offset_t rd_word_i;
  data_t rd_data_o;
  logic rd_valid_o;
  logic wr_error_o;
  logic [ErrCountWidth-1:0] err_count_o;

  // reference model state, kept in step with the DUT pipeline
  rule_t model_map [NoRules];
  data_t model_mem [NoIndices][WordsPerTarget];
  logic pend_we [NoIndices];
  addr_t pend_addr [NoIndices];
  addr_t pend_mask [NoIndices];
  data_t pend_data;
  int model_err_count;
  data_t exp_rd_data;
  logic exp_wr_error;
  logic [ErrCountWidth-1:0] exp_err_count;
  logic wr_seen;

  string test_name = "reset";
  int rd_errors = 0;
  int wr_errors = 0;
  int other_errors = 0;

  always #50 clk_i = ~clk_i;

  mcast_fabric mcast_fabric_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .wr_valid_i     (wr_valid_i),
    .wr_req_i       (wr_req_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_rule_sel_i (cfg_rule_sel_i),
    .cfg_rule_i     (cfg_rule_i),
    .rd_en_i        (rd_en_i),
    .rd_target_i    (rd_target_i),
    .rd_word_i      (rd_word_i),
    .rd_data_o      (rd_data_o),
    .rd_valid_o     (rd_valid_o),
    .wr_error_o     (wr_error_o),
    .err_count_o    (err_count_o)
  );

  // a rule hits when each address bit agrees or is free on one of the two sides
  function automatic logic rule_matches(rule_t rule, addr_t addr, addr_t mask);
    logic hit;
    hit = 1'b1;
    for (int b = 0; b < AddrWidth; b++) begin
      if (!mask[b] && !rule.mask[b] && (addr[b] != rule.addr[b])) begin
        hit = 1'b0;
      end
    end
    return hit;
  endfunction

  // the request's pinned bits are kept, its free bits come from the rule
  function automatic addr_t resolve_addr(rule_t rule, addr_t addr, addr_t mask);
    addr_t res;
    for (int b = 0; b < AddrWidth; b++) begin
      res[b] = mask[b] ? rule.addr[b] : addr[b];
    end
    return res;
  endfunction

  // word j is covered when it equals the offset on every pinned offset bit
  function automatic logic word_covered(addr_t raddr, addr_t rmask, int j);
    offset_t jo;
    logic covered;
    jo = offset_t'(j);
    covered = 1'b1;
    for (int b = 0; b < OffsetWidth; b++) begin
      if (!rmask[b] && (raddr[b] != jo[b])) begin
        covered = 1'b0;
      end
    end
    return covered;
  endfunction

  // one model step per edge
  // the read sees memory before this edge's write lands, and a config
  // strobe only affects requests from the next edge onwards
  always @(posedge clk_i) begin : ref_model
    logic any_hit;
    if (!rst_n_i) begin
      for (int r = 0; r < NoRules; r++) begin
        model_map[r] = '{idx: idx_t'(r), addr: addr_t'(r * 16), mask: 16'h000F};
      end
      for (int t = 0; t < NoIndices; t++) begin
        pend_we[t] = 1'b0;
        for (int j = 0; j < WordsPerTarget; j++) begin
          model_mem[t][j] = '0;
        end
      end
      model_err_count = 0;
      exp_wr_error <= 1'b0;
      exp_err_count <= '0;
      wr_seen <= 1'b0;
    end else begin
      if (rd_en_i) begin
        exp_rd_data <= model_mem[rd_target_i][rd_word_i];
      end
      for (int t = 0; t < NoIndices; t++) begin
        for (int j = 0; j < WordsPerTarget; j++) begin
          if (pend_we[t] && word_covered(pend_addr[t], pend_mask[t], j)) begin
            model_mem[t][j] = pend_data;
          end
        end
        pend_we[t] = 1'b0;
      end
      any_hit = 1'b0;
      // later rules overwrite the resolved set of earlier ones on the same target
      for (int r = 0; r < NoRules; r++) begin
        if (rule_matches(model_map[r], wr_req_i.addr, wr_req_i.mask)) begin
          any_hit = 1'b1;
          pend_we[model_map[r].idx] = wr_valid_i;
          pend_mask[model_map[r].idx] = wr_req_i.mask & model_map[r].mask;
          pend_addr[model_map[r].idx] = resolve_addr(model_map[r], wr_req_i.addr,
                                                     wr_req_i.mask);
        end
      end
      pend_data = wr_req_i.data;
      if (wr_valid_i && !any_hit && model_err_count < 255) begin
        model_err_count++;
      end
      exp_wr_error <= wr_valid_i && !any_hit;
      exp_err_count <= ErrCountWidth'(model_err_count);
      wr_seen <= wr_valid_i;
      if (cfg_we_i) begin
        model_map[cfg_rule_sel_i] = cfg_rule_i;
      end
    end
  end

  rd_data_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_valid_o |-> (rd_data_o == exp_rd_data))
    else begin
      rd_errors++;
      $display("FAIL %s rd_data_o expected %h actual %h", test_name,
               $sampled(exp_rd_data), $sampled(rd_data_o));
    end

  rd_valid_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_valid_o == $past(rd_en_i))
    else begin
      other_errors++;
      $display("%s: rd_valid_o did not follow the read strobe by one cycle", test_name);
    end

  wr_error_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_seen |-> (wr_error_o == exp_wr_error))
    else begin
      wr_errors++;
      $display("FAIL %s wr_error_o expected %0b actual %0b", test_name,
               $sampled(exp_wr_error), $sampled(wr_error_o));
    end

  err_count_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_seen |-> (err_count_o == exp_err_count))
    else begin
      wr_errors++;
      $display("FAIL %s err_count_o expected %0d actual %0d", test_name,
               $sampled(exp_err_count), $sampled(err_count_o));
    end

  task automatic drive_write(input addr_t addr, input addr_t mask);
    data_t data;
    data = $urandom();
    @(posedge clk_i);
    wr_valid_i <= 1'b1;
    wr_req_i <= '{addr: addr, mask: mask, data: data};
  endtask

  task automatic drive_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk_i);
      wr_valid_i <= 1'b0;
      rd_en_i <= 1'b0;
      cfg_we_i <= 1'b0;
    end
  endtask

  task automatic drive_config(input int sel, input rule_t rule);
    @(posedge clk_i);
    wr_valid_i <= 1'b0;
    cfg_we_i <= 1'b1;
    cfg_rule_sel_i <= RuleSelWidth'(sel);
    cfg_rule_i <= rule;
  endtask

  // back-to-back reads of every word, each one checked on its rd_valid_o
  task automatic read_all();
    for (int t = 0; t < NoIndices; t++) begin
      for (int j = 0; j < WordsPerTarget; j++) begin
        @(posedge clk_i);
        wr_valid_i <= 1'b0;
        rd_en_i <= 1'b1;
        rd_target_i <= idx_t'(t);
        rd_word_i <= offset_t'(j);
      end
    end
    drive_idle(3);
  endtask

  initial begin
    #((TestCycles + 200) * 100);
    $display("timeout, the tests did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h45693996));
    rst_n_i = 1'b0;
    wr_valid_i = 1'b0;
    wr_req_i = '0;
    cfg_we_i = 1'b0;
    cfg_rule_sel_i = '0;
    cfg_rule_i = '0;
    rd_en_i = 1'b0;
    rd_target_i = '0;
    rd_word_i = '0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    reset_state: assert (!wr_error_o && !rd_valid_o && err_count_o == '0)
      else begin
        other_errors++;
        $display("reset: outputs are not idle right after reset");
      end
    read_all();

    test_name = "unicast";
    drive_write(16'h0023, 16'h0000);
    drive_idle(2);
    read_all();

    // broadcast and partial set go out on consecutive cycles
    test_name = "broadcast";
    drive_write(16'h0000, 16'h003F);
    test_name = "partial";
    drive_write(16'h0010, 16'h0005);
    drive_idle(2);
    read_all();

    test_name = "unmatched";
    drive_write(16'h8000, 16'h0000);
    drive_idle(2);
    read_all();

    // rule 3 moves to a window for target 0, so its old window is left unmapped
    test_name = "remap";
    drive_config(3, '{idx: idx_t'(0), addr: 16'h0200, mask: 16'h000F});
    drive_write(16'h0207, 16'h0000);
    drive_write(16'h0030, 16'h0000);
    drive_idle(2);
    read_all();

    $display("errors: read %0d, write %0d, other %0d", rd_errors, wr_errors, other_errors);
    if (rd_errors + wr_errors + other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mcast_fabric.f
hw/mcast_pkg.sv
hw/multiaddr_decode.sv
hw/addr_map_regs.sv
hw/mcast_dispatch.sv
hw/mem_target.sv
hw/mcast_fabric.sv
verif/mcast_fabric_tb.sv
